//--- compile.f
verilog/cpu_pkg.sv
verilog/ctrl_pkg.sv
verilog/program_counter.sv
verilog/control_block.sv
verilog/alu.sv
verilog/bus_register.sv
verilog/instruction_register.sv
verilog/ram_16x8.sv
verilog/cpu_top.sv
tests/cpu_tb.sv

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*, ctrl_pkg::*;;

    localparam int NUM_ENTRIES = 8;                        // Last entry is the random add
    localparam int RAND_IDX    = NUM_ENTRIES - 1;
    localparam int TIMEOUT     = 200 * STEPS_PER_INSTR;    // Cycles per wait loop
    localparam int RAND_RUNS   = 8;

    logic  clk = 1'b0;
    logic  reset;
    logic  prog_we;
    addr_t prog_addr;
    data_t prog_data;
    logic  run;
    data_t out_value;
    logic  out_strobe;
    logic  halted;
    logic  carry_flag;
    logic  zero_flag;

    // Program table with address 0 in the top byte of each image
    string        names     [NUM_ENTRIES];
    logic [127:0] images    [NUM_ENTRIES];
    logic [31:0]  exp_outs  [NUM_ENTRIES];   // First output in the top byte
    int           exp_count [NUM_ENTRIES];
    logic         exp_carry [NUM_ENTRIES];
    logic         exp_zero  [NUM_ENTRIES];

    logic [31:0] seed;
    logic [8:0]  rand_sum;   // Sum with carry out
    data_t       x;
    data_t       y;

    cpu_top #(.RAM_WORDS(16)) UUT (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .run(run), .out_value(out_value),
        .out_strobe(out_strobe), .halted(halted), .carry_flag(carry_flag),
        .zero_flag(zero_flag)
    );

    always #10 clk = ~clk;   // 20 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;   // Numerical Recipes constants
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic set_entry(input int idx, input string name, input logic [127:0] image,
                             input int count, input logic [31:0] outs,
                             input logic carry, input logic zero);
        names[idx]     = name;
        images[idx]    = image;
        exp_count[idx] = count;
        exp_outs[idx]  = outs;
        exp_carry[idx] = carry;
        exp_zero[idx]  = zero;
    endtask

    // Reset with run low and held for 5 cycles
    task automatic reset_cpu();
        @(posedge clk);
        reset   <= 1'b1;
        run     <= 1'b0;
        prog_we <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Write all 16 bytes through the load port
    task automatic load_program(input int idx);
        for (int a = 0; a < 16; a++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(a);
            prog_data <= images[idx][127 - 8 * a -: 8];
        end
    endtask

    task automatic execute(input int idx, input string tag);
        data_t got [$];
        int    cycles;
        @(posedge clk);
        run       <= 1'b1;
        prog_we   <= 1'b1;    // Stray load while running must not reach memory
        prog_addr <= '0;
        prog_data <= 8'hFF;   // Would read as HLT if written
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(negedge clk);   // Outputs settled mid cycle
            cycles++;
            if (out_strobe)
                got.push_back(out_value);
        end
        if (!halted) begin
            $display("Timeout: %s did not halt within %0d cycles", tag, TIMEOUT);
            $display("Simulation failed");
            $fatal(1);
        end
        // Nothing may be output once halted
        repeat (2 * STEPS_PER_INSTR) begin
            @(negedge clk);
            check({tag, " strobe after halt"}, 0, out_strobe);
            check({tag, " halted held"}, 1, halted);
        end
        check({tag, " output count"}, exp_count[idx], got.size());
        for (int k = 0; k < exp_count[idx]; k++)
            check($sformatf("%s output %0d", tag, k), exp_outs[idx][31 - 8 * k -: 8], got[k]);
        check({tag, " carry"}, exp_carry[idx], carry_flag);
        check({tag, " zero"}, exp_zero[idx], zero_flag);
        @(posedge clk);
        run     <= 1'b0;
        prog_we <= 1'b0;
    endtask

    task automatic run_entry(input int idx, input bit load_mem, input string tag);
        reset_cpu();
        if (load_mem)
            load_program(idx);
        execute(idx, tag);
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;

        // 200 + 100 wraps to 0x2C with carry
        set_entry(0, "load_add", 128'h0E_1F_E0_F0_00_00_00_00_00_00_00_00_00_00_C8_64,
                  1, 32'h2C00_0000, 1'b1, 1'b0);
        // Equal operands give zero with no borrow
        set_entry(1, "sub_equal", 128'h0E_2F_E0_F0_00_00_00_00_00_00_00_00_00_00_37_37,
                  1, 32'h0000_0000, 1'b1, 1'b1);
        // 0x10 - 0x30 borrows and wraps to 0xE0
        set_entry(2, "sub_wrap", 128'h0E_2F_E0_F0_00_00_00_00_00_00_00_00_00_00_10_30,
                  1, 32'hE000_0000, 1'b0, 1'b0);
        // LDI 9, STA C, LDI 3, OUT, LDA C, OUT, HLT
        set_entry(3, "store_reload", 128'h49_3C_43_E0_0C_E0_F0_00_00_00_00_00_00_00_00_00,
                  2, 32'h0309_0000, 1'b0, 1'b0);
        // JMP over the OUT at address 2
        set_entry(4, "jmp_skip", 128'h45_53_E0_47_E0_F0_00_00_00_00_00_00_00_00_00_00,
                  1, 32'h0700_0000, 1'b0, 1'b0);
        // Count 3 down to 0 and leave on JZ
        set_entry(5, "countdown", 128'h0E_E0_2F_75_51_E0_F0_00_00_00_00_00_00_00_03_01,
                  4, 32'h0302_0100, 1'b1, 1'b1);
        // First JC taken after 0x80 + 0x80 and second not taken after 1 + 1
        // Its target at address 9 halts with no output
        set_entry(6, "jc_branch", 128'h0E_1E_64_E0_41_1D_69_E0_F0_F0_00_00_00_01_80_00,
                  1, 32'h0200_0000, 1'b0, 1'b0);
        // Operands at E and F filled per run
        set_entry(RAND_IDX, "random_add",
                  128'h0E_1F_E0_F0_00_00_00_00_00_00_00_00_00_00_00_00,
                  1, 32'h0000_0000, 1'b0, 1'b0);

        // Second pass runs from memory left by the first
        for (int i = 0; i < RAND_IDX; i++) begin
            run_entry(i, 1'b1, names[i]);
            run_entry(i, 1'b0, {names[i], " rerun"});
        end

        seed = 32'h4375_58b4;
        for (int r = 0; r < RAND_RUNS; r++) begin
            seed = lcg_next(seed);
            x    = seed[31:24];   // Upper bits are the better random ones
            seed = lcg_next(seed);
            y    = seed[31:24];
            images[RAND_IDX][15:8] = x;   // Address E
            images[RAND_IDX][7:0]  = y;   // Address F
            rand_sum = {1'b0, x} + {1'b0, y};
            exp_outs[RAND_IDX]  = {rand_sum[7:0], 24'h0};
            exp_carry[RAND_IDX] = rand_sum[8];
            exp_zero[RAND_IDX]  = (rand_sum[7:0] == 8'h00);
            run_entry(RAND_IDX, 1'b1, $sformatf("%s %0d", names[RAND_IDX], r));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*, ctrl_pkg::*; #(
    parameter int RAM_WORDS = 16
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  prog_we,      // Program byte strobe ignored while running
    input  addr_t prog_addr,
    input  data_t prog_data,
    input  logic  run,          // Low freezes the sequencer
    output data_t out_value,
    output logic  out_strobe,   // One cycle after the output register loads
    output logic  halted,
    output logic  carry_flag,
    output logic  zero_flag
);

    data_t   bus;
    addr_t   pc;
    opcode_t opcode;
    addr_t   operand;
    data_t   a_value;
    data_t   b_value;
    data_t   alu_result;
    data_t   ram_data;
    logic    prog_we_gated;

    logic pc_count, pc_out, pc_load;
    logic mar_load, ram_out, ram_write;
    logic ir_load, ir_out;
    logic a_load, a_out;
    logic alu_sub, alu_out;
    logic b_load, out_load;

    logic [NUM_SRC-1:0] bus_sel;      // One-hot source select
    data_t              bus_src [NUM_SRC];

    assign prog_we_gated = prog_we && !run;

    assign bus_sel[SRC_PC]  = pc_out;
    assign bus_sel[SRC_RAM] = ram_out;
    assign bus_sel[SRC_IR]  = ir_out;
    assign bus_sel[SRC_A]   = a_out;
    assign bus_sel[SRC_ALU] = alu_out;

    assign bus_src[SRC_PC]  = {4'b0, pc};        // Low nibble only
    assign bus_src[SRC_RAM] = ram_data;
    assign bus_src[SRC_IR]  = {4'b0, operand};   // IR drives its operand
    assign bus_src[SRC_A]   = a_value;
    assign bus_src[SRC_ALU] = alu_result;

    // AND-OR mux that reads zero when idle
    always_comb begin
        bus = '0;
        for (int i = 0; i < NUM_SRC; i++)
            if (bus_sel[i])
                bus = bus | bus_src[i];
    end

    // Strobe follows the output register load by one edge
    always_ff @(posedge clk) begin
        if (reset)
            out_strobe <= 1'b0;
        else
            out_strobe <= out_load;
    end

    program_counter u_pc (
        .clk(clk), .reset(reset), .count(pc_count), .load(pc_load),
        .bus_in(bus[ADDR_W-1:0]), .pc(pc)
    );

    control_block u_ctrl (
        .clk(clk), .reset(reset), .run(run), .opcode(opcode),
        .carry_flag(carry_flag), .zero_flag(zero_flag),
        .pc_count(pc_count), .pc_out(pc_out), .pc_load(pc_load),
        .mar_load(mar_load), .ram_out(ram_out), .ram_write(ram_write),
        .ir_load(ir_load), .ir_out(ir_out), .a_load(a_load), .a_out(a_out),
        .alu_sub(alu_sub), .alu_out(alu_out), .b_load(b_load),
        .out_load(out_load), .halt(), .halted(halted)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .enable(alu_out), .sub(alu_sub),
        .a(a_value), .b(b_value), .result(alu_result),
        .carry_flag(carry_flag), .zero_flag(zero_flag)
    );

    bus_register accumulator (     // A register
        .clk(clk), .reset(reset), .load(a_load), .bus_in(bus), .value(a_value)
    );

    bus_register b_register (
        .clk(clk), .reset(reset), .load(b_load), .bus_in(bus), .value(b_value)
    );

    bus_register output_register (
        .clk(clk), .reset(reset), .load(out_load), .bus_in(bus), .value(out_value)
    );

    instruction_register u_ir (
        .clk(clk), .reset(reset), .load(ir_load), .bus_in(bus),
        .opcode(opcode), .operand(operand)
    );

    ram_16x8 #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk(clk), .mar_load(mar_load), .write(ram_write), .bus_in(bus),
        .prog_we(prog_we_gated), .prog_addr(prog_addr), .prog_data(prog_data),
        .data_out(ram_data)
    );

endmodule

//--- verilog/ram_16x8.sv
`timescale 1ns/1ps

module ram_16x8 import cpu_pkg::*; #(
    parameter int RAM_WORDS = 16   // 16 or a smaller power of two
) (
    input  logic  clk,
    input  logic  mar_load,    // MAR takes the bus
    input  logic  write,       // CPU store at MAR
    input  data_t bus_in,
    input  logic  prog_we,     // Program load, already gated by run
    input  addr_t prog_addr,
    input  data_t prog_data,
    output data_t data_out     // Word at MAR
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    addr_t mar;                        // Memory address register
    data_t mem [RAM_WORDS];
    logic [AW-1:0] mar_idx;
    logic [AW-1:0] prog_idx;

    assign mar_idx  = mar[AW-1:0];     // Upper address bits ignored in a small memory
    assign prog_idx = prog_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (mar_load)
            mar <= bus_in[ADDR_W-1:0];
    end

    // CPU store and program load share the array
    always_ff @(posedge clk) begin
        if (write)
            mem[mar_idx] <= bus_in;
        else if (prog_we)
            mem[prog_idx] <= prog_data;
    end

    assign data_out = mem[mar_idx];    // Combinational read

    // Loading only happens while stopped, so the CPU cannot store then
    assert property (@(posedge clk) !(prog_we && write))
        else $error("ram_16x8: program load during CPU write");

endmodule

//--- verilog/instruction_register.sv
`timescale 1ns/1ps

module instruction_register import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    load,      // Fetch step
    input  data_t   bus_in,    // Byte from memory
    output opcode_t opcode,    // Upper nibble
    output addr_t   operand    // Lower nibble
);

    data_t instr;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (load) begin
            instr <= bus_in;
        end
    end

    // Split the fetched byte
    assign opcode  = opcode_t'(instr[7:4]);
    assign operand = instr[ADDR_W-1:0];

    // Undefined opcodes pass through as is, control treats them as no-op

endmodule

//--- verilog/bus_register.sv
`timescale 1ns/1ps

module bus_register import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load,     // Capture the bus at the next edge
    input  data_t bus_in,
    output data_t value
);

    data_t value_q;

    always_ff @(posedge clk) begin
        if (reset)
            value_q <= '0;
        else if (load)
            value_q <= bus_in;   // Holds otherwise
    end

    assign value = value_q;

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  enable,       // Result goes onto the bus, flags update
    input  logic  sub,          // Subtract when high
    input  data_t a,            // Accumulator
    input  data_t b,            // B register
    output data_t result,
    output logic  carry_flag,
    output logic  zero_flag
);

    logic [DATA_W:0] sum;       // Carry in the top bit
    data_t           b_operand;

    // Two's complement subtract is A + ~B + 1
    assign b_operand = sub ? ~b : b;
    assign sum       = {1'b0, a} + {1'b0, b_operand} + {{DATA_W{1'b0}}, sub};
    assign result    = sum[DATA_W-1:0];

    // Flags only move on the edge that writes the result back
    always_ff @(posedge clk) begin
        if (reset) begin
            carry_flag <= 1'b0;
            zero_flag  <= 1'b0;
        end else if (enable) begin
            carry_flag <= sum[DATA_W];         // Set means no borrow on subtract
            zero_flag  <= (result == '0);
        end
    end

endmodule

//--- verilog/control_block.sv
`timescale 1ns/1ps

module control_block import cpu_pkg::*, ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    run,          // Sequencer advances only while high
    input  opcode_t opcode,       // From the instruction register
    input  logic    carry_flag,
    input  logic    zero_flag,
    output logic    pc_count,
    output logic    pc_out,
    output logic    pc_load,
    output logic    mar_load,
    output logic    ram_out,
    output logic    ram_write,
    output logic    ir_load,
    output logic    ir_out,
    output logic    a_load,
    output logic    a_out,
    output logic    alu_sub,
    output logic    alu_out,
    output logic    b_load,
    output logic    out_load,
    output logic    halt,
    output logic    halted        // Sticky until reset
);

    step_t step;
    logic  active;                // Sequencer allowed to act this cycle
    logic [NUM_SRC-1:0] bus_src;  // Bus drivers, used for the contention check

    assign active = run && !halted;

    // Step register, frozen while stopped and held at T2 by HLT
    always_ff @(posedge clk) begin
        if (reset) begin
            step   <= T0;
            halted <= 1'b0;
        end else begin
            if (halt)
                halted <= 1'b1;   // Set at the end of T2 of HLT
            if (active && !halt)
                step <= (step == T4) ? T0 : step_t'(step + 3'd1);
        end
    end

    // Microcode decode
    always_comb begin
        pc_count  = 1'b0;
        pc_out    = 1'b0;
        pc_load   = 1'b0;
        mar_load  = 1'b0;
        ram_out   = 1'b0;
        ram_write = 1'b0;
        ir_load   = 1'b0;
        ir_out    = 1'b0;
        a_load    = 1'b0;
        a_out     = 1'b0;
        alu_sub   = 1'b0;
        alu_out   = 1'b0;
        b_load    = 1'b0;
        out_load  = 1'b0;
        halt      = 1'b0;
        if (active) begin
            case (step)
                T0: begin pc_out = 1'b1; mar_load = 1'b1; end
                T1: begin ram_out = 1'b1; ir_load = 1'b1; pc_count = 1'b1; end
                T2: begin
                    case (opcode)
                        LDA, ADD, SUB, STA: begin ir_out = 1'b1; mar_load = 1'b1; end
                        LDI: begin ir_out = 1'b1; a_load = 1'b1; end
                        JMP: begin ir_out = 1'b1; pc_load = 1'b1; end
                        JC:  begin ir_out = carry_flag; pc_load = carry_flag; end
                        JZ:  begin ir_out = zero_flag; pc_load = zero_flag; end
                        OUT: begin a_out = 1'b1; out_load = 1'b1; end
                        HLT: halt = 1'b1;
                        default: ;   // Unused codes idle
                    endcase
                end
                T3: begin
                    case (opcode)
                        LDA:      begin ram_out = 1'b1; a_load = 1'b1; end
                        ADD, SUB: begin ram_out = 1'b1; b_load = 1'b1; end
                        STA:      begin a_out = 1'b1; ram_write = 1'b1; end
                        default: ;
                    endcase
                end
                T4: begin
                    if (opcode == ADD || opcode == SUB) begin
                        alu_out = 1'b1;
                        a_load  = 1'b1;
                        alu_sub = (opcode == SUB);
                    end
                end
                default: ;
            endcase
        end
    end

    assign bus_src[SRC_PC]  = pc_out;
    assign bus_src[SRC_RAM] = ram_out;
    assign bus_src[SRC_IR]  = ir_out;
    assign bus_src[SRC_A]   = a_out;
    assign bus_src[SRC_ALU] = alu_out;

    // The bus mux in cpu_top relies on at most one driver
    assert property (@(posedge clk) disable iff (reset) $onehot0(bus_src))
        else $error("control_block: bus contention, sources %b", bus_src);

endmodule

//--- verilog/program_counter.sv
`timescale 1ns/1ps

module program_counter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  count,    // Increment at the next edge
    input  logic  load,     // Jump target from the bus
    input  addr_t bus_in,   // Low nibble of the bus
    output addr_t pc
);

    addr_t pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else if (load) begin   // Jump wins over count
            pc_q <= bus_in;
        end else if (count) begin
            pc_q <= pc_q + addr_t'(1);   // Wraps 15 -> 0
        end
    end

    assign pc = pc_q;

    // Fetch increment and jump load sit in different microsteps
    assert property (@(posedge clk) disable iff (reset) !(count && load))
        else $error("program_counter: count and load high together");

endmodule

//--- verilog/ctrl_pkg.sv
package ctrl_pkg;

    // Microstep of the current instruction
    typedef enum logic [2:0] {
        T0 = 3'd0,   // PC to MAR
        T1 = 3'd1,   // Fetch into IR, bump PC
        T2 = 3'd2,   // First execute step
        T3 = 3'd3,   // Second execute step
        T4 = 3'd4    // Third execute step
    } step_t;

    // Every instruction takes the full five steps
    localparam int STEPS_PER_INSTR = 5;

    // Positions of the bus-driving lines in a source select vector
    localparam int SRC_PC  = 0;   // pc_out
    localparam int SRC_RAM = 1;   // ram_out
    localparam int SRC_IR  = 2;   // ir_out
    localparam int SRC_A   = 3;   // a_out
    localparam int SRC_ALU = 4;   // alu_out

    // Number of bus sources
    localparam int NUM_SRC = 5;

    // Only one source may be active in a cycle,
    // the bus reads zero when none is active

endpackage

//--- verilog/cpu_pkg.sv
package cpu_pkg;

    // Word and address widths of the datapath
    localparam int DATA_W = 8;   // Bus, memory and register width
    localparam int ADDR_W = 4;   // Program counter and MAR width

    // One bus or memory word
    typedef logic [DATA_W-1:0] data_t;

    // Memory or program counter address
    typedef logic [ADDR_W-1:0] addr_t;

    // Upper nibble of every instruction
    typedef enum logic [3:0] {
        LDA = 4'd0,    // A <- mem[operand]
        ADD = 4'd1,    // A <- A + mem[operand]
        SUB = 4'd2,    // A <- A - mem[operand]
        STA = 4'd3,    // mem[operand] <- A
        LDI = 4'd4,    // A <- operand, zero extended
        JMP = 4'd5,    // PC <- operand
        JC  = 4'd6,    // PC <- operand when carry set
        JZ  = 4'd7,    // PC <- operand when zero set
        OUT = 4'd14,   // Output register <- A
        HLT = 4'd15    // Stop the sequencer
    } opcode_t;

    // Codes 8 to 13 decode to no operation

endpackage
